// ==== z80BusPkg.sv ====
// Machine-cycle function and T-state enums, sequencer state struct
`default_nettype none

package z80BusPkg;

    // ------------------------------------------------------------------
    // Machine-cycle functions
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        funcFetch    = 3'd0,  // Opcode fetch, M1 cycle
        funcMemRead  = 3'd1,  // Memory read
        funcMemWrite = 3'd2,  // Memory write
        funcIoRead   = 3'd3,  // I/O read
        funcIoWrite  = 3'd4   // I/O write
    } cycleFunc;

    // ------------------------------------------------------------------
    // Sequencer T-states
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        stIdle = 3'd0,  // No cycle running
        stT1   = 3'd1,
        stT2   = 3'd2,
        stTw1  = 3'd3,  // Automatic wait states of the INT acknowledge
        stTw2  = 3'd4,
        stWait = 3'd5,  // WAIT-driven extension of the test state
        stT3   = 3'd6,
        stT4   = 3'd7
    } tState;

    // Where the running cycle stands, broadcast to decoder and pads
    typedef struct packed {
        cycleFunc func;     // Function latched at request
        tState    state;    // Current T-state
        logic     intrAck;  // Fetch is an interrupt acknowledge
    } seqState;

endpackage

`default_nettype wire

// ==== z80PadPkg.sv ====
// Control-pin bundle and pad-control strobe structs
`default_nettype none

package z80PadPkg;

    // Bus control pins, all active high inside the core
    typedef struct packed {
        logic m1;    // Opcode fetch phase
        logic mreq;  // Memory request
        logic iorq;  // I/O request or INT acknowledge
        logic rd;    // Read strobe
        logic wr;    // Write strobe
        logic rfsh;  // Refresh phase
    } pinBus;

    // ------------------------------------------------------------------
    // Strobes from the pin decoder to the address and data pads
    // ------------------------------------------------------------------
    typedef struct packed {
        logic addrWe;     // Load bus address into the address latch
        logic refreshWe;  // Put refresh address on the bus
        logic dataOe;     // Drive write data onto the data bus
        logic dataRe;     // Capture the data bus into the read latch
    } padCtrl;

endpackage

`default_nettype wire

// ==== cycleSequencer.sv ====
// T-state FSM for fetch, memory and I/O machine cycles
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer (
    input  wire                  setM1,      // Clock
    input  wire                  arstN,
    input  wire                  cycleReq,   // One-clock request strobe
    input  z80BusPkg::cycleFunc  reqFunc,
    input  wire                  intrAck,    // Fetch is an INT acknowledge
    input  wire                  holdWait,   // WAIT seen in test or wait state
    input  wire                  busack,
    output z80BusPkg::seqState   seq,
    output logic                 ready,      // Idle and bus not granted
    output logic                 cycleDone   // Final T-state of the cycle
);

    import z80BusPkg::*;

    tState    stateQ;
    tState    stateD;
    cycleFunc funcQ;
    logic     intrQ;
    logic     isIo;     // I/O cycles test WAIT in T3 and end in T4
    logic     isMem;    // Memory read/write end in T3

    assign isIo  = (funcQ == funcIoRead) || (funcQ == funcIoWrite);
    assign isMem = (funcQ == funcMemRead) || (funcQ == funcMemWrite);

    assign ready     = (stateQ == stIdle) && !busack;
    assign cycleDone = (stateQ == stT4) || ((stateQ == stT3) && isMem && !holdWait);

    // ------------------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------------------
    always_comb begin
        stateD = stateQ;
        case (stateQ)
            stIdle: if (cycleReq && ready) stateD = stT1;
            stT1:   stateD = stT2;
            stT2: begin
                if (intrQ) stateD = stTw1;          // INT ack inserts two Tw
                else if (holdWait) stateD = stWait; // Only set in mem/fetch T2
                else stateD = stT3;
            end
            stTw1:  stateD = stTw2;
            stTw2: begin
                if (holdWait) stateD = stWait;
                else stateD = stT3;
            end
            stWait: begin
                // Resume at the state after the test state
                if (!holdWait) begin
                    if (isIo) stateD = stT4;
                    else stateD = stT3;
                end
            end
            stT3: begin
                if (holdWait) stateD = stWait;      // I/O test state
                else if (isMem) stateD = stIdle;
                else stateD = stT4;
            end
            stT4:   stateD = stIdle;
            default: stateD = stIdle;
        endcase
    end

    // State, function and INT flag registers
    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) begin
            stateQ <= stIdle;
            funcQ  <= funcFetch;
            intrQ  <= 1'b0;
        end else begin
            stateQ <= stateD;
            if (stateQ == stIdle && cycleReq && ready) begin
                funcQ <= reqFunc;
                intrQ <= intrAck && (reqFunc == funcFetch); // Only fetch acks
            end
        end
    end

    always_comb begin
        seq.func    = funcQ;
        seq.state   = stateQ;
        seq.intrAck = intrQ;
    end

endmodule

`default_nettype wire

// ==== pinDecoder.sv ====
// Bus pin levels, pad strobes, WAIT hold and BUSRQ/BUSACK
`timescale 1ns/1ps
`default_nettype none

module pinDecoder (
    input  wire                 setM1,
    input  wire                 arstN,
    input  z80BusPkg::seqState  seq,
    input  wire                 cycleDone,
    input  wire                 extWait,   // WAIT pin level
    input  wire                 busrq,     // BUSRQ pin level
    output z80PadPkg::pinBus    pins,
    output z80PadPkg::padCtrl   ctrl,
    output logic                holdWait,  // Hold the sequencer in stWait
    output logic                busack
);

    import z80BusPkg::*;

    tState testSt;   // State where WAIT is tested
    tState capSt;    // State whose end captures read data
    tState effSt;    // State whose pin levels apply
    logic  isFetch, isIntFetch, isMemRd, isMemWr, isIoRd, isIoWr;
    logic  t1, t2, tw1, tw2, t3, t4;

    assign isFetch    = (seq.func == funcFetch) && !seq.intrAck;
    assign isIntFetch = (seq.func == funcFetch) && seq.intrAck;
    assign isMemRd    = seq.func == funcMemRead;
    assign isMemWr    = seq.func == funcMemWrite;
    assign isIoRd     = seq.func == funcIoRead;
    assign isIoWr     = seq.func == funcIoWrite;

    // ------------------------------------------------------------------
    // Test and capture states per function
    // ------------------------------------------------------------------
    always_comb begin
        testSt = stT2;               // Plain fetch and memory cycles
        capSt  = stT2;               // Plain fetch captures at end of T2
        if (isIntFetch) begin
            testSt = stTw2;
            capSt  = stTw2;
        end else if (isIoRd || isIoWr) begin
            testSt = stT3;
        end
        if (isMemRd) capSt = stT3;
        if (isIoRd) capSt = stT4;
    end

    // Wait states repeat the test-state pins
    assign effSt = (seq.state == stWait) ? testSt : seq.state;

    assign t1  = effSt == stT1;
    assign t2  = effSt == stT2;
    assign tw1 = effSt == stTw1;
    assign tw2 = effSt == stTw2;
    assign t3  = effSt == stT3;
    assign t4  = effSt == stT4;

    // ------------------------------------------------------------------
    // Pin levels at whole T-state resolution
    // ------------------------------------------------------------------
    always_comb begin
        pins.m1   = (isFetch && (t1 || t2)) || (isIntFetch && (t1 || t2 || tw1 || tw2));
        pins.mreq = (isFetch && (t1 || t2 || t3)) || (isIntFetch && t3)
                  || ((isMemRd || isMemWr) && (t1 || t2 || t3));
        pins.iorq = (isIntFetch && (tw1 || tw2)) || ((isIoRd || isIoWr) && (t2 || t3 || t4));
        pins.rd   = (isFetch && (t1 || t2)) || (isMemRd && (t1 || t2 || t3))
                  || (isIoRd && (t2 || t3 || t4));
        pins.wr   = (isMemWr && (t2 || t3)) || (isIoWr && (t2 || t3 || t4));
        pins.rfsh = (isFetch || isIntFetch) && (t3 || t4);  // Refresh after opcode read
    end

    assign holdWait = extWait && ((seq.state == testSt) || (seq.state == stWait));

    // Pad strobes
    always_comb begin
        ctrl.addrWe    = t1;
        ctrl.refreshWe = (isFetch || isIntFetch) && t3;
        ctrl.dataOe    = (isMemWr && (t1 || t2 || t3)) || (isIoWr && (t1 || t2 || t3 || t4));
        ctrl.dataRe    = (isFetch || isIntFetch || isMemRd || isIoRd)
                       && (effSt == capSt) && !holdWait;  // Last sample only
    end

    // BUSRQ is sampled at cycle end, in idle, and every clock while granted
    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) begin
            busack <= 1'b0;
        end else if (busack || cycleDone || seq.state == stIdle) begin
            busack <= busrq;
        end
    end

endmodule

`default_nettype wire

// ==== addressPad.sv ====
// Address output latch and refresh counter
`timescale 1ns/1ps
`default_nettype none

module addressPad #(
    parameter int addrWidth   = 16,
    parameter int refreshBits = 7
) (
    input  wire                   setM1,
    input  wire                   arstN,
    input  z80PadPkg::padCtrl     ctrl,
    input  wire                   busack,
    input  wire [addrWidth-1:0]   reqAddr,
    output logic [addrWidth-1:0]  addrOut,
    output logic                  addrOe      // Low while the bus is granted
);

    logic [addrWidth-1:0]   addrLatch;
    logic [refreshBits-1:0] refreshCnt;   // R counter, wraps naturally
    logic [addrWidth-1:0]   refreshAddr;

    assign refreshAddr = {{(addrWidth - refreshBits){1'b0}}, refreshCnt};

    // New address shows in the load state itself, the latch holds it after
    always_comb begin
        if (ctrl.addrWe) addrOut = reqAddr;
        else if (ctrl.refreshWe) addrOut = refreshAddr;
        else addrOut = addrLatch;
    end

    always_ff @(posedge setM1) begin
        if (ctrl.addrWe || ctrl.refreshWe) addrLatch <= addrOut;
    end

    // Step once per fetch, next fetch shows the following count
    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) refreshCnt <= '0;
        else if (ctrl.refreshWe) refreshCnt <= refreshCnt + 1'b1;
    end

    assign addrOe = !busack;

endmodule

`default_nettype wire

// ==== dataPad.sv ====
// Write-data latch, read-data capture and read-valid pulse
`timescale 1ns/1ps
`default_nettype none

module dataPad #(
    parameter int dataWidth = 8
) (
    input  wire                   setM1,
    input  wire                   arstN,
    input  z80PadPkg::padCtrl     ctrl,
    input  wire                   busack,
    input  wire                   cycleReq,
    input  wire [dataWidth-1:0]   reqWrData,
    input  wire [dataWidth-1:0]   extDataIn,   // Data bus input level
    output logic [dataWidth-1:0]  dataOut,
    output logic                  dataOe,
    output logic [dataWidth-1:0]  readData,
    output logic                  readValid    // One clock after capture
);

    logic [dataWidth-1:0] wrLatch;

    // Never reload while write data is on the bus
    always_ff @(posedge setM1) begin
        if (cycleReq && !busack && !ctrl.dataOe) wrLatch <= reqWrData;
    end

    assign dataOut = wrLatch;
    assign dataOe  = ctrl.dataOe && !busack;

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------
    always_ff @(posedge setM1) begin
        if (ctrl.dataRe) readData <= extDataIn;  // Sample at end of capture state
    end

    always_ff @(posedge setM1 or negedge arstN) begin
        if (!arstN) readValid <= 1'b0;
        else readValid <= ctrl.dataRe;
    end

endmodule

`default_nettype wire

// ==== z80BusUnit.sv ====
// Top level joining sequencer, pin decoder and the two pads
`timescale 1ns/1ps
`default_nettype none

module z80BusUnit #(
    parameter int addrWidth   = 16,
    parameter int dataWidth   = 8,
    parameter int refreshBits = 7
) (
    input  wire                   setM1,      // Clock
    input  wire                   arstN,
    input  wire                   cycleReq,
    input  z80BusPkg::cycleFunc   reqFunc,
    input  wire [addrWidth-1:0]   reqAddr,
    input  wire [dataWidth-1:0]   reqWrData,
    input  wire                   intrAck,
    input  wire                   extWait,    // WAIT
    input  wire                   busrq,
    input  wire [dataWidth-1:0]   extDataIn,
    output z80PadPkg::pinBus      pins,
    output wire                   busack,
    output wire [addrWidth-1:0]   addrOut,
    output wire                   addrOe,
    output wire [dataWidth-1:0]   dataOut,
    output wire                   dataOe,
    output wire [dataWidth-1:0]   readData,
    output wire                   readValid,
    output wire                   ready,
    output wire                   cycleDone
);

    import z80BusPkg::*;
    import z80PadPkg::*;

    seqState seq;        // Sequencer broadcast
    padCtrl  ctrl;       // Pad strobes
    logic    holdWait;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    cycleSequencer i_cycleSequencer (
        .setM1, .arstN, .cycleReq, .reqFunc, .intrAck, .holdWait, .busack,
        .seq, .ready, .cycleDone
    );

    pinDecoder i_pinDecoder (
        .setM1, .arstN, .seq, .cycleDone, .extWait, .busrq,
        .pins, .ctrl, .holdWait, .busack
    );

    // ------------------------------------------------------------------
    // Pads
    // ------------------------------------------------------------------
    addressPad #(.addrWidth(addrWidth), .refreshBits(refreshBits)) i_addressPad (
        .setM1, .arstN, .ctrl, .busack, .reqAddr, .addrOut, .addrOe
    );

    dataPad #(.dataWidth(dataWidth)) i_dataPad (
        .setM1, .arstN, .ctrl, .busack, .cycleReq, .reqWrData, .extDataIn,
        .dataOut, .dataOe, .readData, .readValid
    );

endmodule

`default_nettype wire

// ==== z80BusUnitTb.sv ====
// Testbench for the bus unit: clock, reset, cases-file stimulus, expected pins and compare tasks
`timescale 1ns/1ps
`default_nettype none

module z80BusUnitTb;

    import z80BusPkg::*;
    import z80PadPkg::*;

    localparam int addrWidth   = 16;
    localparam int dataWidth   = 8;
    localparam int refreshBits = 7;
    localparam int waitLimit   = 40;   // Clocks before any wait gives up

    // DUT signals
    logic                 setM1, arstN, cycleReq, intrAck, extWait, busrq;
    cycleFunc             reqFunc;
    logic [addrWidth-1:0] reqAddr, addrOut;
    logic [dataWidth-1:0] reqWrData, extDataIn, dataOut, readData;
    pinBus                pins;
    logic                 busack, addrOe, dataOe, readValid, ready, cycleDone;

    // Current case, one line of the cases file
    string                curName, funcName, line;
    int                   intrVal, curWaits, busrqVal, curLen, fd, n;
    logic [31:0]          addrVal, wrVal, extVal, expReadVal;
    cycleFunc             curFunc;
    bit                   curIntr, curWrite, curBusrq;

    tState                steps[$];    // Expected T-state of each clock in the cycle
    tState                testState;   // Repeated by the wait states
    int                   testIdx;
    logic [refreshBits-1:0] refreshCnt; // Expected R count of the next fetch
    int                   errors, timeouts, caseCount;
    bit                   timedOut;

    z80BusUnit #(
        .addrWidth(addrWidth), .dataWidth(dataWidth), .refreshBits(refreshBits)
    ) i_z80BusUnit (.*);

    initial begin
        setM1 = 1'b0;
        forever #2 setM1 = ~setM1;   // 4 ns period
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic checkPins(input string what, input pinBus expV, input pinBus actV);
        if (actV !== expV) begin
            errors++;
            $display("Fail %s expected %b actual %b", what, expV, actV);
        end
    endtask

    task automatic checkData(input string what, input logic [dataWidth-1:0] expV,
                             input logic [dataWidth-1:0] actV);
        if (actV !== expV) begin
            errors++;
            $display("Fail %s expected %h actual %h", what, expV, actV);
        end
    endtask

    task automatic checkAddr(input string what, input logic [addrWidth-1:0] expV,
                             input logic [addrWidth-1:0] actV);
        if (actV !== expV) begin
            errors++;
            $display("Fail %s expected %h actual %h", what, expV, actV);
        end
    endtask

    task automatic checkCount(input string what, input int expV, input int actV);
        if (actV != expV) begin
            errors++;
            $display("Fail %s expected %0d actual %0d", what, expV, actV);
        end
    endtask

    task automatic checkFlag(input string what, input logic expV, input logic actV);
        if (actV !== expV) begin
            errors++;
            $display("Fail %s expected %b actual %b", what, expV, actV);
        end
    endtask

    task automatic reportTimeout(input string what);
        timeouts++;
        timedOut = 1'b1;
        $display("Timeout in case %s: %s", curName, what);
    endtask

    // Pin levels per function and T-state, straight from the timing table
    function automatic pinBus expectPins(input cycleFunc f, input bit intr, input tState st);
        pinBus p;
        p = '0;
        case (f)
            funcFetch: begin
                p.m1   = intr ? st inside {stT1, stT2, stTw1, stTw2} : st inside {stT1, stT2};
                p.mreq = intr ? st == stT3 : st inside {stT1, stT2, stT3};
                p.iorq = intr && st inside {stTw1, stTw2};  // INT ack, no RD
                p.rd   = !intr && st inside {stT1, stT2};
                p.rfsh = st inside {stT3, stT4};
            end
            funcMemRead:  {p.mreq, p.rd} = {2{st inside {stT1, stT2, stT3}}};
            funcMemWrite: begin
                p.mreq = st inside {stT1, stT2, stT3};
                p.wr   = st inside {stT2, stT3};
            end
            funcIoRead:   {p.iorq, p.rd} = {2{st inside {stT2, stT3, stT4}}};
            funcIoWrite:  {p.iorq, p.wr} = {2{st inside {stT2, stT3, stT4}}};
            default:      p = '0;
        endcase
        return p;
    endfunction

    // Map the function column, derive the per-case flags
    function automatic bit decodeCase();
        case (funcName)
            "fetch": curFunc = funcFetch;
            "memRd": curFunc = funcMemRead;
            "memWr": curFunc = funcMemWrite;
            "ioRd":  curFunc = funcIoRead;
            "ioWr":  curFunc = funcIoWrite;
            default: return 1'b0;
        endcase
        curIntr  = (intrVal != 0) && (curFunc == funcFetch);
        curWrite = (curFunc == funcMemWrite) || (curFunc == funcIoWrite);
        curBusrq = busrqVal != 0;
        return 1'b1;
    endfunction

    // Expected T-states of one cycle, wait states right after the test state
    task automatic buildSteps();
        steps.delete();
        steps.push_back(stT1);
        steps.push_back(stT2);
        if (curIntr) begin
            steps.push_back(stTw1);   // Automatic waits of INT ack
            steps.push_back(stTw2);
        end
        if (curFunc inside {funcIoRead, funcIoWrite}) steps.push_back(stT3);
        testIdx   = steps.size() - 1;
        testState = steps[testIdx];
        repeat (curWaits) steps.push_back(stWait);
        if (curFunc inside {funcIoRead, funcIoWrite}) steps.push_back(stT4);
        else steps.push_back(stT3);
        if (curFunc == funcFetch) steps.push_back(stT4);
    endtask

    task automatic sampleRead(input string tag, inout bit gotRead);
        if (readValid) begin
            if (curWrite) begin
                errors++;
                $display("readValid pulsed during write cycle %s", tag);
            end else begin
                checkData({tag, " readData"}, expReadVal[dataWidth-1:0], readData);
            end
            gotRead = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------
    // One bus cycle: request, per-clock checks, grant and read result
    // ------------------------------------------------------------------
    task automatic runCase();
        int    count;
        int    t;
        bit    done;
        bit    gotRead;
        pinBus expPins;
        string tag;
        caseCount++;
        gotRead = curWrite;   // Nothing to read in write cycles
        buildSteps();
        t = 0;
        @(negedge setM1);
        while (!ready && t < waitLimit) begin
            @(negedge setM1);
            t++;
        end
        if (!ready) begin
            reportTimeout("ready stayed low before the request");
            return;
        end
        @(posedge setM1);
        cycleReq  <= 1'b1;
        reqFunc   <= curFunc;
        intrAck   <= curIntr;
        reqAddr   <= addrVal[addrWidth-1:0];
        reqWrData <= wrVal[dataWidth-1:0];
        extDataIn <= extVal[dataWidth-1:0];
        @(posedge setM1);     // This edge enters T1
        cycleReq <= 1'b0;
        count = 0;
        done  = 1'b0;
        while (!done && count < waitLimit) begin
            @(negedge setM1);
            tag = $sformatf("%s step %0d", curName, count);
            if (count < steps.size()) begin
                expPins = expectPins(curFunc, curIntr,
                                     steps[count] == stWait ? testState : steps[count]);
                checkPins({tag, " pins"}, expPins, pins);
                checkFlag({tag, " dataOe"}, curWrite, dataOe);
                checkFlag({tag, " addrOe"}, 1'b1, addrOe);
                if (curWrite) checkData({tag, " dataOut"}, wrVal[dataWidth-1:0], dataOut);
                if (steps[count] == stT1)
                    checkAddr({tag, " addrOut"}, addrVal[addrWidth-1:0], addrOut);
                if (curFunc == funcFetch && steps[count] == stT3)   // Refresh address
                    checkAddr({tag, " refresh"},
                              {{(addrWidth - refreshBits){1'b0}}, refreshCnt}, addrOut);
            end
            sampleRead(tag, gotRead);
            done = cycleDone;
            count++;
            @(posedge setM1);
            extWait <= (count >= testIdx) && (count < testIdx + curWaits);  // N high samples
            if (count == 1) busrq <= curBusrq;   // Seen first at cycleDone
        end
        if (!done) begin
            reportTimeout("cycleDone did not rise");
            return;
        end
        checkCount({curName, " cycle length"}, curLen, count);
        if (curFunc == funcFetch) refreshCnt++;
        @(negedge setM1);
        sampleRead(curName, gotRead);
        checkFlag({curName, " busack"}, curBusrq, busack);
        t = 0;
        while (busack && t < waitLimit) begin   // Bus granted, pads off
            checkFlag({curName, " ready in grant"}, 1'b0, ready);
            checkFlag({curName, " addrOe in grant"}, 1'b0, addrOe);
            checkFlag({curName, " dataOe in grant"}, 1'b0, dataOe);
            @(posedge setM1);
            if (t == 2) busrq <= 1'b0;          // Release after a short grant
            @(negedge setM1);
            t++;
        end
        if (busack) begin
            reportTimeout("busack stayed high after busrq fell");
            return;
        end
        if (curBusrq) checkFlag({curName, " ready after grant"}, 1'b1, ready);
        t = 0;
        while (!gotRead && t < waitLimit) begin
            @(negedge setM1);
            sampleRead(curName, gotRead);
            t++;
        end
        if (!gotRead) reportTimeout("readValid did not pulse");
    endtask

    initial begin
        errors     = 0;
        timeouts   = 0;
        caseCount  = 0;
        timedOut   = 1'b0;
        refreshCnt = '0;
        arstN     <= 1'b0;
        cycleReq  <= 1'b0;
        reqFunc   <= funcFetch;
        reqAddr   <= '0;
        reqWrData <= '0;
        intrAck   <= 1'b0;
        extWait   <= 1'b0;
        busrq     <= 1'b0;
        extDataIn <= '0;
        repeat (10) @(posedge setM1);
        arstN <= 1'b1;
        fd = $fopen("z80BusCases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the cases file z80BusCases.txt");
        end
        while (fd != 0 && !$feof(fd) && !timedOut) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin   // Skip blanks and column notes
                n = $sscanf(line, "%s %s %d %h %h %h %d %d %h %d", curName, funcName,
                            intrVal, addrVal, wrVal, extVal, curWaits, busrqVal,
                            expReadVal, curLen);
                if (n == 10 && decodeCase()) begin
                    runCase();
                end else begin
                    errors++;
                    $display("Could not use this line of the cases file: %s", line);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        $display("Cases %0d, errors %0d, timeouts %0d", caseCount, errors, timeouts);
        if (errors == 0 && timeouts == 0 && caseCount > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== z80BusCases.txt ====
# name func(fetch memRd memWr ioRd ioWr) intrAck addr(hex) wrData(hex) extDataIn(hex)
# waits busrq expReadData(hex) expCycleLength
fetchPlain        fetch 0 0100 00 3e 0 0 3e 4
memRead           memRd 0 8000 00 a5 0 0 a5 3
memWrite          memWr 0 8001 5a 00 0 0 00 3
ioRead            ioRd  0 0040 00 c3 0 0 c3 4
ioWrite           ioWr  0 0041 96 00 0 0 00 4
fetchWait2        fetch 0 0101 00 77 2 0 77 6
memReadWait1      memRd 0 9000 00 12 1 0 12 4
memWriteWait3     memWr 0 9001 e7 00 3 0 00 6
ioReadWait2       ioRd  0 00fe 00 81 2 0 81 6
ioWriteWait1      ioWr  0 00ff 3c 00 1 0 00 5
intAck            fetch 1 0000 00 ff 0 0 ff 6
intAckWait2       fetch 1 0000 00 38 2 0 38 8
fetchRefresh      fetch 0 0102 00 c9 0 0 c9 4
memReadGrant      memRd 0 a000 00 4e 0 1 4e 3
fetchAfterGrant   fetch 0 0103 00 00 0 0 00 4
memWriteGrant     memWr 0 a001 11 00 1 1 00 4
ioReadAfterGrant  ioRd  0 0010 00 6d 0 0 6d 4

// ==== z80BusUnit.f ====
z80BusPkg.sv
z80PadPkg.sv
cycleSequencer.sv
pinDecoder.sv
addressPad.sv
dataPad.sv
z80BusUnit.sv
z80BusUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module z80BusUnitTb \
    -f z80BusUnit.f -o simZ80BusUnit
output=$(./obj_dir/simZ80BusUnit)
echo "$output"
if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
